//--- dac_pkg.sv
package dac_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths of one DAC frame
	//////////////////////////////////////////////////////////////////////

	// DAC code width
	localparam int DATA_W = 12;
	// Channel address width
	localparam int ADDR_W = 4;
	// Command nibble width
	localparam int CMD_W = 4;
	// Leading and trailing don't-care bits, sent as zeros
	localparam int PAD_HI_W = 8;
	localparam int PAD_LO_W = 4;
	// Full serial frame, 32 SCK rising edges
	localparam int FRAME_W = PAD_HI_W + CMD_W + ADDR_W + DATA_W + PAD_LO_W;
	// Bit counter for the shifter, 5 bits for 32
	localparam int CNT_W = $clog2(FRAME_W);

	//////////////////////////////////////////////////////////////////////
	// Command buffer
	//////////////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 4;
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// Consumer FSM states
	localparam int STATE_W = 2;
	localparam logic [STATE_W-1:0] TRIG_WAITING = 2'd0;
	localparam logic [STATE_W-1:0] TRIGGING = 2'd1;
	localparam logic [STATE_W-1:0] WAITING_DONE = 2'd2;
	localparam logic [STATE_W-1:0] DONE = 2'd3;

	// One frame word, packed as fields, shifted as raw bits
	typedef union packed {
		struct packed {
			logic [PAD_HI_W-1:0] pad_hi;
			logic [CMD_W-1:0]    command;
			logic [ADDR_W-1:0]   address;
			logic [DATA_W-1:0]   data;
			logic [PAD_LO_W-1:0] pad_lo;
		} fields;
		logic [FRAME_W-1:0] raw;
	} dac_frame_u;

endpackage

//--- dac_cmd_packer.sv
`timescale 1ns/1ps

module dac_cmd_packer import dac_pkg::*; (
	input  logic              CLK50MHZ,
	input  logic              RST,
	input  logic [DATA_W-1:0] data,
	input  logic [ADDR_W-1:0] address,
	input  logic [CMD_W-1:0]  command,
	input  logic              wr,
	input  logic              ovf_clr,
	input  logic              full,
	output logic              push,
	output dac_frame_u        push_frame,
	output logic              overflow
);

	// Registered write waiting for its push cycle
	logic pending;
	// Pending write refused by a full buffer
	logic drop;

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			pending <= 1'b0;
		end else begin
			pending <= wr;
		end
	end

	// Frame payload, loaded on every host write
	always_ff @(posedge CLK50MHZ) begin
		if (wr) begin
			push_frame.fields.pad_hi <= '0;
			push_frame.fields.command <= command;
			push_frame.fields.address <= address;
			push_frame.fields.data <= data;
			push_frame.fields.pad_lo <= '0;
		end
	end

	// Push only into free space, full is current for this cycle
	assign push = pending & ~full;
	assign drop = pending & full;

	//////////////////////////////////////////////////////////////////////
	// Sticky overflow
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			overflow <= 1'b0;
		end else if (drop) begin
			// A fresh drop wins over a clear in the same cycle
			overflow <= 1'b1;
		end else if (ovf_clr) begin
			overflow <= 1'b0;
		end
	end

endmodule

//--- dac_cmd_fifo.sv
`timescale 1ns/1ps

module dac_cmd_fifo import dac_pkg::*; (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic       push,
	input  dac_frame_u push_frame,
	input  logic       pop,
	output dac_frame_u pop_frame,
	output logic       full,
	output logic       empty
);

	// Frame storage
	dac_frame_u mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Occupancy, one bit wider than the pointers
	logic [PTR_W:0] count;
	logic [PTR_W:0] count_next;
	logic do_push;
	logic do_pop;

	// Pointer step with wrap at the last entry
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Guard against push when full and pop when empty
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	always_comb begin
		count_next = count;
		case ({do_push, do_pop})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			// Simultaneous push and pop keeps the count
			default: count_next = count;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers, count and levels
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count_next;
			// Levels from the next count, valid right after the edge
			full <= (count_next == (PTR_W + 1)'(FIFO_DEPTH));
			empty <= (count_next == '0);
		end
	end

	// Storage write
	always_ff @(posedge CLK50MHZ) begin
		if (do_push) begin
			mem[wr_ptr] <= push_frame;
		end
	end

	// Head entry, visible while not empty
	assign pop_frame = mem[rd_ptr];

endmodule

//--- dacsend.sv
`timescale 1ns/1ps

module dacsend import dac_pkg::*; (
	input  logic       RST,
	input  logic       SPI_SCK,
	input  dac_frame_u frame_hold,
	input  logic       trig_tgl,
	output logic       done_tgl,
	output logic       DAC_CS,
	output logic       dac_in
);

	// Reset brought into the SCK domain
	logic rst_meta;
	logic rst_sync;
	// Request toggle sync and edge detect
	logic trig_meta;
	logic trig_sync;
	logic trig_seen;
	logic trig_edge;
	// High while a frame is on the wire
	logic sending;
	logic [FRAME_W-1:0] shreg;
	logic [CNT_W-1:0] bit_cnt;

	//////////////////////////////////////////////////////////////////////
	// Everything here runs on falling SCK edges
	//////////////////////////////////////////////////////////////////////

	// Plain two-flop chain
	always_ff @(negedge SPI_SCK) begin
		rst_meta <= RST;
		rst_sync <= rst_meta;
	end

	always_ff @(negedge SPI_SCK) begin
		if (!rst_sync) begin
			trig_meta <= 1'b0;
			trig_sync <= 1'b0;
			trig_seen <= 1'b0;
		end else begin
			trig_meta <= trig_tgl;
			trig_sync <= trig_meta;
			trig_seen <= trig_sync;
		end
	end

	// A level kept through reset still shows up as an edge afterwards
	assign trig_edge = trig_sync ^ trig_seen;

	// Frame control and bit count
	always_ff @(negedge SPI_SCK) begin
		if (!rst_sync) begin
			sending <= 1'b0;
			bit_cnt <= '0;
			done_tgl <= 1'b0;
		end else if (!sending) begin
			if (trig_edge) begin
				sending <= 1'b1;
				bit_cnt <= '0;
			end
		end else if (bit_cnt == CNT_W'(FRAME_W - 1)) begin
			// LSB sampled on the last rising edge, release CS now
			sending <= 1'b0;
			done_tgl <= ~done_tgl;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Shift register, MSB goes out first
	always_ff @(negedge SPI_SCK) begin
		if (!sending && trig_edge) begin
			shreg <= frame_hold.raw;
		end else if (sending) begin
			shreg <= {shreg[FRAME_W-2:0], 1'b0};
		end
	end

	// Chip select low only during the 32 bits
	assign DAC_CS = ~sending;
	// Data line parked low between frames
	assign dac_in = sending & shreg[FRAME_W-1];

endmodule

//--- dacspi.sv
`timescale 1ns/1ps

module dacspi import dac_pkg::*; (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic       SPI_SCK,
	input  dac_frame_u pop_frame,
	input  logic       empty,
	output logic       pop,
	output logic       DAC_CS,
	output logic       DAC_CLR,
	output logic       dac_in,
	// Readback pin of the DAC, not read in this design
	input  logic       DAC_OUT,
	output logic       dacdone
);

	logic [STATE_W-1:0] state;
	// Frame in flight, held for the SCK domain
	dac_frame_u frame_hold;
	// Request toggle towards the shifter
	logic trig_tgl;
	// Completion toggle back from the shifter
	logic done_tgl;
	// Two-flop sync of done_tgl plus previous value
	logic done_meta;
	logic done_sync;
	logic done_seen;
	logic done_edge;

	//////////////////////////////////////////////////////////////////////
	// Shifter in the SPI_SCK domain
	//////////////////////////////////////////////////////////////////////

	dacsend dacsend_i (
		.RST        (RST),
		.SPI_SCK    (SPI_SCK),
		.frame_hold (frame_hold),
		.trig_tgl   (trig_tgl),
		.done_tgl   (done_tgl),
		.DAC_CS     (DAC_CS),
		.dac_in     (dac_in)
	);

	// DAC clear pin, low in reset, high one cycle after release
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			DAC_CLR <= 1'b0;
		end else begin
			DAC_CLR <= 1'b1;
		end
	end

	// Completion toggle into CLK50MHZ
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			done_meta <= 1'b0;
			done_sync <= 1'b0;
			done_seen <= 1'b0;
		end else begin
			done_meta <= done_tgl;
			done_sync <= done_meta;
			done_seen <= done_sync;
		end
	end

	// Either edge of the toggle means one frame sent
	assign done_edge = done_sync ^ done_seen;

	//////////////////////////////////////////////////////////////////////
	// Frame handoff FSM
	//////////////////////////////////////////////////////////////////////

	// Pop whenever idle and something is queued
	assign pop = (state == TRIG_WAITING) & ~empty;

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			state <= TRIG_WAITING;
			trig_tgl <= 1'b0;
		end else begin
			case (state)
				TRIG_WAITING: begin
					if (pop) begin
						state <= TRIGGING;
					end
				end
				TRIGGING: begin
					// frame_hold already settled one cycle before the toggle
					trig_tgl <= ~trig_tgl;
					state <= WAITING_DONE;
				end
				WAITING_DONE: begin
					if (done_edge) begin
						state <= DONE;
					end
				end
				DONE: begin
					state <= TRIG_WAITING;
				end
				default: begin
					state <= TRIG_WAITING;
				end
			endcase
		end
	end

	// Hold register, loaded only on pop
	always_ff @(posedge CLK50MHZ) begin
		if (pop) begin
			frame_hold <= pop_frame;
		end
	end

	// One-cycle done pulse
	assign dacdone = (state == DONE);

endmodule

//--- dac_top.sv
`timescale 1ns/1ps

module dac_top import dac_pkg::*; (
	input  logic              CLK50MHZ,
	input  logic              RST,
	input  logic              SPI_SCK,
	input  logic [DATA_W-1:0] data,
	input  logic [ADDR_W-1:0] address,
	input  logic [CMD_W-1:0]  command,
	input  logic              wr,
	input  logic              ovf_clr,
	output logic              DAC_CS,
	output logic              DAC_CLR,
	output logic              dac_in,
	input  logic              DAC_OUT,
	output logic              dacdone,
	output logic              overflow
);

	// Packer to buffer
	logic push;
	dac_frame_u push_frame;
	logic full;
	// Buffer to consumer
	logic pop;
	dac_frame_u pop_frame;
	logic empty;

	//////////////////////////////////////////////////////////////////////
	// Producer, buffer, consumer
	//////////////////////////////////////////////////////////////////////

	dac_cmd_packer packer_i (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.data       (data),
		.address    (address),
		.command    (command),
		.wr         (wr),
		.ovf_clr    (ovf_clr),
		.full       (full),
		.push       (push),
		.push_frame (push_frame),
		.overflow   (overflow)
	);

	dac_cmd_fifo fifo_i (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.push       (push),
		.push_frame (push_frame),
		.pop        (pop),
		.pop_frame  (pop_frame),
		.full       (full),
		.empty      (empty)
	);

	// Consumer with the SCK shifter inside
	dacspi dacspi_i (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.SPI_SCK   (SPI_SCK),
		.pop_frame (pop_frame),
		.empty     (empty),
		.pop       (pop),
		.DAC_CS    (DAC_CS),
		.DAC_CLR   (DAC_CLR),
		.dac_in    (dac_in),
		.DAC_OUT   (DAC_OUT),
		.dacdone   (dacdone)
	);

endmodule

//--- dac_top_properties.sv
`timescale 1ns/1ps

module dac_top_properties import dac_pkg::*; (
	input logic CLK50MHZ,
	input logic RST,
	input logic DAC_CS,
	input logic push,
	input logic pop,
	input logic full,
	input logic dacdone
);

	// Buffer occupancy seen from the push and pop strobes
	logic [PTR_W:0] occupancy;

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			occupancy <= '0;
		end else begin
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: ;
			endcase
		end
	end

	// Chip select parked high while reset is held
	cs_high_in_reset: assert property (@(posedge CLK50MHZ) !RST |-> DAC_CS)
		else $error("DAC_CS went low while RST was asserted");

	// Packer only pushes into free space
	no_push_when_full: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		push |-> (occupancy < FIFO_DEPTH))
		else $error("push asserted while the command FIFO was full");

	// Done is a one-cycle pulse
	done_single_cycle: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		dacdone |=> !dacdone)
		else $error("dacdone stayed high for more than one cycle");

endmodule

// Attach to every dac_top, internal packer and FIFO nets included
bind dac_top dac_top_properties dac_top_properties_i (
	.CLK50MHZ (CLK50MHZ),
	.RST      (RST),
	.DAC_CS   (DAC_CS),
	.push     (push),
	.pop      (pop),
	.full     (full),
	.dacdone  (dacdone)
);

//--- tb_dac_top.sv
`timescale 1ns/1ps

module tb_dac_top import dac_pkg::*; ();

	logic CLK50MHZ;
	logic RST;
	logic SPI_SCK;
	logic [DATA_W-1:0] data;
	logic [ADDR_W-1:0] address;
	logic [CMD_W-1:0] command;
	logic wr;
	logic ovf_clr;
	logic DAC_OUT;
	logic DAC_CS;
	logic DAC_CLR;
	logic dac_in;
	logic dacdone;
	logic overflow;

	// Parsed vector steps, one entry per W, C, D or O line
	logic [7:0] op_q[$];
	int arg_a_q[$];
	int arg_b_q[$];
	int arg_c_q[$];
	// Expected serial frames in send order
	logic [FRAME_W-1:0] exp_q[$];
	int w_lines = 0;
	int limit = 2000;
	int cycle_count = 0;
	int rx_count = 0;
	int done_count = 0;
	// Serial capture
	dac_frame_u cap;
	int nbits = 0;

	dac_top dac_top_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.SPI_SCK  (SPI_SCK),
		.data     (data),
		.address  (address),
		.command  (command),
		.wr       (wr),
		.ovf_clr  (ovf_clr),
		.DAC_CS   (DAC_CS),
		.DAC_CLR  (DAC_CLR),
		.dac_in   (dac_in),
		.DAC_OUT  (DAC_OUT),
		.dacdone  (dacdone),
		.overflow (overflow)
	);

	//////////////////////////////////////////////////////////////////////
	// Clocks
	//////////////////////////////////////////////////////////////////////

	// 50 MHz system clock
	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	// 10 MHz SCK, offset so its edges never meet CLK50MHZ edges
	initial begin
		SPI_SCK = 1'b1;
		#3;
		forever #50 SPI_SCK = ~SPI_SCK;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// Whole vector file into the step queues
	task automatic read_vectors();
		int fd;
		int a;
		int b;
		int c;
		logic [7:0] op;
		string line;
		fd = $fopen("dac_vectors.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open dac_vectors.txt for reading");
		end
		while (!$feof(fd)) begin
			line = "";
			a = 0;
			b = 0;
			c = 0;
			if ($fgets(line, fd) == 0) begin
				continue;
			end
			void'($sscanf(line, "%c", op));
			case (op)
				"W": begin
					if ($sscanf(line, "%c %h %h %h", op, a, b, c) != 4) begin
						abort_run($sformatf("Write line is missing fields: %s", line));
					end
					w_lines = w_lines + 1;
				end
				"D", "O": void'($sscanf(line, "%c %d", op, a));
				"E": begin
					void'($sscanf(line, "%c %h", op, a));
					exp_q.push_back(FRAME_W'(a));
				end
				"C", "#", 8'h0a, 8'h0d: ;
				default: abort_run($sformatf("Unknown line in the vector file: %s", line));
			endcase
			// Steps that drive or sample the DUT
			if (op == "W" || op == "D" || op == "O" || op == "C") begin
				op_q.push_back(op);
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				arg_c_q.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// One step per falling edge, inputs held until the next one
	task automatic run_vectors();
		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				"W": begin
					@(negedge CLK50MHZ);
					command = CMD_W'(arg_a_q[i]);
					address = ADDR_W'(arg_b_q[i]);
					data = DATA_W'(arg_c_q[i]);
					wr = 1'b1;
					ovf_clr = 1'b0;
				end
				"C": begin
					@(negedge CLK50MHZ);
					wr = 1'b0;
					ovf_clr = 1'b1;
				end
				"D": begin
					repeat (arg_a_q[i]) begin
						@(negedge CLK50MHZ);
						wr = 1'b0;
						ovf_clr = 1'b0;
					end
				end
				"O": begin
					@(negedge CLK50MHZ);
					wr = 1'b0;
					ovf_clr = 1'b0;
					check_value($sformatf("overflow at step %0d", i), 32'(arg_a_q[i]),
						32'(overflow));
				end
				default: ;
			endcase
		end
		@(negedge CLK50MHZ);
		wr = 1'b0;
		ovf_clr = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitors and timeout
	//////////////////////////////////////////////////////////////////////

	// DAC side sampling, MSB first on rising SCK while CS is low
	always @(posedge SPI_SCK) begin
		if (DAC_CS) begin
			nbits = 0;
		end else begin
			cap.raw = {cap.raw[FRAME_W-2:0], dac_in};
			nbits = nbits + 1;
			if (nbits == FRAME_W) begin
				if (rx_count >= exp_q.size()) begin
					abort_run("A frame appeared on the serial line with none left to expect");
				end
				// Zero padding on its own, then the whole word
				check_value($sformatf("frame %0d padding", rx_count), 32'd0,
					32'({cap.fields.pad_hi, cap.fields.pad_lo}));
				check_value($sformatf("frame %0d", rx_count), exp_q[rx_count], cap.raw);
				rx_count = rx_count + 1;
				nbits = 0;
			end
		end
	end

	// dacdone pulses, sampled between CLK50MHZ edges
	always @(negedge CLK50MHZ) begin
		if (RST && dacdone) begin
			done_count = done_count + 1;
		end
	end

	always @(posedge CLK50MHZ) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > limit) begin
			abort_run($sformatf("Timeout after %0d cycles, the frames never all arrived",
				cycle_count));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		RST = 1'b0;
		data = '0;
		address = '0;
		command = '0;
		wr = 1'b0;
		ovf_clr = 1'b0;
		DAC_OUT = 1'b0;
		read_vectors();
		limit = 2000 + 200 * w_lines;
		// Reset over 4 rising edges
		repeat (4) @(negedge CLK50MHZ);
		check_value("DAC_CS in reset", 32'd1, 32'(DAC_CS));
		check_value("DAC_CLR in reset", 32'd0, 32'(DAC_CLR));
		RST = 1'b1;
		@(negedge CLK50MHZ);
		check_value("DAC_CLR after reset", 32'd1, 32'(DAC_CLR));
		check_value("DAC_CS after reset", 32'd1, 32'(DAC_CS));
		check_value("dac_in after reset", 32'd0, 32'(dac_in));
		check_value("dacdone after reset", 32'd0, 32'(dacdone));
		check_value("overflow after reset", 32'd0, 32'(overflow));
		run_vectors();
		// Drain the buffer and the serial link
		while (rx_count < exp_q.size() || done_count < exp_q.size()) begin
			@(negedge CLK50MHZ);
		end
		// Quiet time long enough for any stray frame
		repeat (400) @(negedge CLK50MHZ);
		check_value("dacdone count", 32'(exp_q.size()), 32'(done_count));
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- dac_vectors.txt
# W cmd addr data (hex) | D idle cycles (dec) | C ovf_clr pulse | O overflow level (dec)
# E expected 32-bit serial frame (hex), in send order
W 3 0 ABC
E 0030ABC0
D 300
W 3 1 123
D 40
W 3 2 456
D 40
W 3 3 789
E 00311230
E 00324560
E 00337890
D 700
O 0
# One write, then six back to back, the last two are dropped
W 3 4 111
D 1
W 3 5 001
W 3 6 002
W 3 7 003
W 3 8 004
W 3 9 005
W 3 A 006
E 00341110
E 00350010
E 00360020
E 00370030
E 00380040
D 2
O 1
C
D 1
O 0
D 1000
W 3 F FFF
E 003FFFF0
D 2
O 0

//--- vlog.f
dac_pkg.sv
dac_cmd_packer.sv
dac_cmd_fifo.sv
dacsend.sv
dacspi.sv
dac_top.sv
dac_top_properties.sv
tb_dac_top.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the DAC SPI testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_dac_top -f vlog.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit 1
fi

if grep -F -q '*** PASSED ***' sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
